// File: build.f
+incdir+.
usb_pkg.sv
usb_rx_reg_pkg.sv
usb_bit_if.sv
usb_line_recovery.sv
usb_packet_framer.sv
usb_packet_decoder.sv
usb_rx_fifo.sv
usb_rx_apb_regs.sv
usb_rx_top.sv
tb_usb_rx.sv

// File: run_sim.sh
#!/bin/sh
# build and run the usb receive testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f build.f --top-module tb_usb_rx --Mdir obj_dir -o tb_usb_rx_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_usb_rx_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
  exit 1
fi
exit 0

// File: tb_usb_host_tasks.svh
////////////////////
// usb line driver

// hold one line state for a full bit of 4 clocks
task automatic drive_line(input logic [1:0] state);
  logic [31:0] rnd;
  int          cycles;
  rnd    = $urandom();
  cycles = 4;
  // a J/K swap may move one wire a clock ahead of the other
  if (skew_en && rnd[1] && (state[1] != dp) && (state[0] != dn)) begin
    if (rnd[0]) begin
      dp = state[1];
    end else begin
      dn = state[0];
    end
    @(negedge clk_48mhz);
    cycles = 3;
  end
  dp = state[1];
  dn = state[0];
  repeat (cycles) begin
    @(negedge clk_48mhz);
  end
endtask

// nrzi, a zero toggles the line
task automatic send_bit(input logic value, input logic stuffing);
  if (!value) begin
    line_level = ~line_level;
  end
  drive_line(line_level);
  ones_run = value ? ones_run + 1 : 0;
  // six ones in a row get a forced transition
  if (stuffing && (ones_run == 6)) begin
    line_level = ~line_level;
    drive_line(line_level);
    ones_run = 0;
  end
endtask

// sync, body from tx_bits, eop and a short idle
task automatic send_packet();
  int i;
  line_level = usb_pkg::LS_J;
  // seven zeros and a one give KJKJKJKK
  for (i = 0; i < 8; i++) begin
    send_bit(i == 7, 1'b0);
  end
  // stuffing run starts fresh after sync
  ones_run = 0;
  for (i = 0; i < tx_bits.size(); i++) begin
    send_bit(tx_bits[i], 1'b1);
  end
  drive_line(usb_pkg::LS_SE0);
  drive_line(usb_pkg::LS_SE0);
  drive_line(usb_pkg::LS_J);
  drive_line(usb_pkg::LS_J);
  drive_line(usb_pkg::LS_J);
endtask

////////////////////
// apb master

// setup, access, then wait for pready
task automatic apb_transfer(input logic write, input logic [usb_rx_reg_pkg::APB_ADDR_W-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
  int waited;
  waited = 0;
  @(negedge clk_48mhz);
  psel    = 1'b1;
  penable = 1'b0;
  pwrite  = write;
  paddr   = addr;
  pwdata  = wdata;
  @(negedge clk_48mhz);
  penable = 1'b1;
  @(negedge clk_48mhz);
  while (!pready) begin
    waited++;
    if (waited > APB_TIMEOUT) begin
      stop_with_failure("the APB slave never raised pready");
    end
    @(negedge clk_48mhz);
  end
  rdata = prdata;
  err   = pslverr;
  // held through the completing edge, pops land there
  @(negedge clk_48mhz);
  psel    = 1'b0;
  penable = 1'b0;
  pwrite  = 1'b0;
endtask

task automatic apb_read(input logic [usb_rx_reg_pkg::APB_ADDR_W-1:0] addr,
                        output logic [31:0] rdata);
  logic err;
  apb_transfer(1'b0, addr, 32'd0, rdata, err);
  check_value("pslverr", {31'd0, err}, 32'd0);
endtask

task automatic apb_write(input logic [usb_rx_reg_pkg::APB_ADDR_W-1:0] addr,
                         input logic [31:0] wdata);
  logic [31:0] rdata;
  logic        err;
  apb_transfer(1'b1, addr, wdata, rdata, err);
  check_value("pslverr", {31'd0, err}, 32'd0);
endtask

// File: tb_usb_rx.sv
`timescale 1ns/100ps

module tb_usb_rx;

  localparam int PKT_DEPTH    = 4;
  localparam int DATA_DEPTH   = 64;
  localparam int APB_TIMEOUT  = 16;
  localparam int POLL_TIMEOUT = 64;

  logic        clk_48mhz = 1'b0;
  logic        reset;
  logic        dp;
  logic        dn;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [usb_rx_reg_pkg::APB_ADDR_W-1:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  // packet body after sync, before stuffing, in wire order
  logic                  tx_bits [$];
  // model of both fifos
  usb_pkg::usb_pkt_rec_t exp_recs [$];
  logic [7:0]            exp_bytes [$];
  logic [1:0]            line_level;
  int                    ones_run;
  logic                  skew_en;
  logic [31:0]           seed_ret;

  usb_rx_top #(
    .PKT_FIFO_DEPTH (PKT_DEPTH),
    .DATA_FIFO_DEPTH(DATA_DEPTH)
  ) uut (
    .clk_48mhz(clk_48mhz),
    .reset    (reset),
    .dp       (dp),
    .dn       (dn),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr)
  );

  // 48 mhz nominal, 4 ns here
  always #2 clk_48mhz = ~clk_48mhz;

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      stop_with_failure($sformatf("FAILED %s: got 0x%08h, expected 0x%08h", name, got,
                                  expected));
    end
  endtask

  `include "tb_usb_host_tasks.svh"

  ////////////////////
  // packet builder

  // fields go out lsb first
  task automatic push_field(input logic [15:0] value, input int width);
    int i;
    for (i = 0; i < width; i++) begin
      tx_bits.push_back(value[i]);
    end
  endtask

  // crc register over every bit after the pid
  function automatic logic [15:0] crc_over(input int first, input int width);
    logic [15:0] crc;
    logic [15:0] poly;
    logic        fb;
    int          i;
    poly = (width == 5) ? 16'(usb_pkg::CRC5_POLY) : usb_pkg::CRC16_POLY;
    crc  = (width == 5) ? 16'(usb_pkg::CRC5_SEED) : usb_pkg::CRC16_SEED;
    for (i = first; i < tx_bits.size(); i++) begin
      fb  = tx_bits[i] ^ crc[width-1];
      crc = {crc[14:0], 1'b0} ^ (fb ? poly : 16'd0);
    end
    return crc;
  endfunction

  // inverted crc, msb first, optionally with one bit flipped
  task automatic append_crc(input int width, input logic flip);
    logic [15:0] crc;
    int          i;
    crc = ~crc_over(8, width);
    for (i = width - 1; i >= 0; i--) begin
      tx_bits.push_back(crc[i]);
    end
    if (flip) begin
      i = tx_bits.size() - 1 - int'($urandom_range(width - 1, 0));
      tx_bits[i] = ~tx_bits[i];
    end
  endtask

  task automatic start_packet(input logic [3:0] pid, input logic bad_pid);
    logic [3:0]  comp;
    logic [31:0] rnd;
    rnd  = $urandom();
    comp = ~pid;
    if (bad_pid) begin
      comp[rnd[1:0]] = ~comp[rnd[1:0]];
    end
    tx_bits.delete();
    push_field({12'd0, pid}, 4);
    push_field({12'd0, comp}, 4);
  endtask

  function automatic usb_pkg::usb_pkt_rec_t make_record(input logic [3:0] pid, input logic ok,
                                                        input logic [10:0] payload,
                                                        input logic [9:0] count);
    usb_pkg::usb_pkt_rec_t r;
    r.pid           = pid;
    r.ok            = ok;
    r.token_payload = payload;
    r.byte_count    = count;
    return r;
  endfunction

  task automatic token_packet(input logic [3:0] pid, input logic [10:0] payload,
                              input logic bad_crc, input logic bad_pid);
    start_packet(pid, bad_pid);
    push_field({5'd0, payload}, 11);
    append_crc(5, bad_crc);
    exp_recs.push_back(make_record(pid, !(bad_crc || bad_pid), payload, 10'd0));
    send_packet();
  endtask

  task automatic data_packet(input logic [3:0] pid, input int len, input logic all_ones,
                             input logic bad_crc);
    logic [7:0]  data;
    logic [31:0] rnd;
    int          i;
    int          j;
    start_packet(pid, 1'b0);
    for (i = 0; i < len; i++) begin
      rnd  = $urandom();
      data = all_ones ? 8'hff : rnd[7:0];
      push_field({8'd0, data}, 8);
    end
    append_crc(16, bad_crc);
    // every 8 bits after the pid make a byte, lsb first, crc bytes too
    for (i = 8; i < tx_bits.size(); i += 8) begin
      for (j = 0; j < 8; j++) begin
        data[j] = tx_bits[i + j];
      end
      exp_bytes.push_back(data);
    end
    exp_recs.push_back(make_record(pid, !bad_crc, 11'd0, 10'(len + 2)));
    send_packet();
  endtask

  task automatic handshake_packet(input logic [3:0] pid);
    start_packet(pid, 1'b0);
    exp_recs.push_back(make_record(pid, 1'b1, 11'd0, 10'd0));
    send_packet();
  endtask

  ////////////////////
  // readback

  task automatic wait_status(input int bit_pos);
    logic [31:0] status;
    int          polls;
    polls = 0;
    apb_read(usb_rx_reg_pkg::REG_STATUS, status);
    while (!status[bit_pos]) begin
      polls++;
      if (polls > POLL_TIMEOUT) begin
        stop_with_failure($sformatf("STATUS bit %0d never came up", bit_pos));
      end
      apb_read(usb_rx_reg_pkg::REG_STATUS, status);
    end
  endtask

  // records, then bytes, then both fifos empty with no overflow
  task automatic drain_and_check();
    logic [31:0]           rdata;
    usb_pkg::usb_pkt_rec_t exp;
    while (exp_recs.size() > 0) begin
      wait_status(usb_rx_reg_pkg::STAT_PKT_AVAIL);
      apb_read(usb_rx_reg_pkg::REG_PKT, rdata);
      exp = exp_recs.pop_front();
      check_value("prdata REG_PKT", rdata, 32'(exp));
    end
    while (exp_bytes.size() > 0) begin
      apb_read(usb_rx_reg_pkg::REG_DATA, rdata);
      check_value("prdata REG_DATA", rdata, {24'd0, exp_bytes.pop_front()});
    end
    apb_read(usb_rx_reg_pkg::REG_STATUS, rdata);
    check_value("prdata REG_STATUS", rdata, 32'd0);
  endtask

  ////////////////////
  // test sequence

  initial begin
    logic [31:0]           rnd;
    logic [31:0]           rdata;
    logic                  err;
    usb_pkg::usb_pkt_rec_t exp;
    int                    n;
    seed_ret   = $urandom(32'h49a62ec1);
    reset      = 1'b1;
    dp         = 1'b1;
    dn         = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = 32'd0;
    skew_en    = 1'b0;
    line_level = usb_pkg::LS_J;
    ones_run   = 0;
    repeat (2) begin
      @(negedge clk_48mhz);
    end
    reset = 1'b0;

    // tokens, all four token pids are {sel, 01}
    for (n = 0; n < 12; n++) begin
      rnd = $urandom();
      token_packet({rnd[1:0], usb_pkg::PT_TOKEN}, rnd[20:10], 1'b0, 1'b0);
      drain_and_check();
    end

    // DATA0 and DATA1 with 0 to 20 bytes
    for (n = 0; n < 10; n++) begin
      rnd = $urandom();
      data_packet({rnd[0], 1'b0, usb_pkg::PT_DATA}, int'($urandom_range(20, 0)), 1'b0, 1'b0);
      drain_and_check();
    end

    // bad crc5, bad pid complement, bad crc16, then handshakes
    for (n = 0; n < 4; n++) begin
      rnd = $urandom();
      token_packet({rnd[1:0], usb_pkg::PT_TOKEN}, rnd[20:10], 1'b1, 1'b0);
      token_packet({rnd[3:2], usb_pkg::PT_TOKEN}, rnd[31:21], 1'b0, 1'b1);
      data_packet({rnd[4], 1'b0, usb_pkg::PT_DATA}, int'($urandom_range(20, 0)), 1'b0, 1'b1);
      handshake_packet({rnd[6:5], usb_pkg::PT_HANDSHAKE});
      drain_and_check();
    end

    // long runs of ones force stuffed bits
    token_packet({2'b11, usb_pkg::PT_TOKEN}, 11'h7ff, 1'b0, 1'b0);
    for (n = 0; n < 4; n++) begin
      data_packet({n[0], 1'b0, usb_pkg::PT_DATA}, int'($urandom_range(20, 1)), 1'b1, 1'b0);
      drain_and_check();
    end

    // dp and dn edges a clock apart
    skew_en = 1'b1;
    for (n = 0; n < 8; n++) begin
      rnd = $urandom();
      token_packet({rnd[1:0], usb_pkg::PT_TOKEN}, rnd[20:10], 1'b0, 1'b0);
      data_packet({rnd[2], 1'b0, usb_pkg::PT_DATA}, int'($urandom_range(20, 0)), rnd[3], 1'b0);
      drain_and_check();
    end
    skew_en = 1'b0;

    // one more packet than the record fifo holds
    for (n = 0; n < PKT_DEPTH + 1; n++) begin
      rnd = $urandom();
      token_packet({rnd[1:0], usb_pkg::PT_TOKEN}, rnd[20:10], 1'b0, 1'b0);
    end
    wait_status(usb_rx_reg_pkg::STAT_PKT_OVF);
    for (n = 0; n < PKT_DEPTH; n++) begin
      apb_read(usb_rx_reg_pkg::REG_PKT, rdata);
      exp = exp_recs.pop_front();
      check_value("prdata REG_PKT", rdata, 32'(exp));
    end
    // last record was dropped
    exp_recs.delete();
    apb_read(usb_rx_reg_pkg::REG_STATUS, rdata);
    check_value("prdata REG_STATUS", rdata, 32'd1 << usb_rx_reg_pkg::STAT_PKT_OVF);
    apb_write(usb_rx_reg_pkg::REG_CLEAR, 32'd1 << usb_rx_reg_pkg::STAT_PKT_OVF);
    apb_read(usb_rx_reg_pkg::REG_STATUS, rdata);
    check_value("prdata REG_STATUS", rdata, 32'd0);

    // unmapped offsets have a nonzero low pair
    rnd = $urandom();
    apb_transfer(1'b0, {rnd[3:2], (rnd[1:0] == 2'b00) ? 2'b01 : rnd[1:0]}, 32'd0, rdata, err);
    check_value("pslverr", {31'd0, err}, 32'd1);
    apb_transfer(1'b1, {rnd[5:4], 2'b10}, rnd, rdata, err);
    check_value("pslverr", {31'd0, err}, 32'd1);

    // empty fifos read as zero
    apb_read(usb_rx_reg_pkg::REG_PKT, rdata);
    check_value("prdata REG_PKT", rdata, 32'd0);
    apb_read(usb_rx_reg_pkg::REG_DATA, rdata);
    check_value("prdata REG_DATA", rdata, 32'd0);

    $display("Simulation PASSED");
    $finish;
  end

  // whole run stays far below this
  initial begin
    #(2_000_000);
    stop_with_failure("watchdog expired before the test sequence finished");
  end

endmodule

// File: usb_bit_if.sv
`timescale 1ns/100ps

// unstuffed bit stream from framer to decoder, no back-pressure
interface usb_bit_if;
  // sync seen
  logic start;
  logic bit_valid;
  logic bit_data;
  // eop seen
  logic done;

  modport producer (output start, output bit_valid, output bit_data, output done);
  modport consumer (input start, input bit_valid, input bit_data, input done);
endinterface

// File: usb_line_recovery.sv
`timescale 1ns/100ps

module usb_line_recovery (
  input  logic                clk_48mhz,
  input  logic                reset,
  input  logic                dp,
  input  logic                dn,
  output usb_pkg::line_state_t line_state,
  output logic                sample
);

  // {dp, dn} through two flops
  logic [1:0] pair_meta;
  logic [1:0] pair_sync;
  logic       in_transition;
  logic [1:0] bit_phase;

  always_ff @(posedge clk_48mhz) begin
    if (reset) begin
      // idle bus is J
      pair_meta <= 2'b10;
      pair_sync <= 2'b10;
    end else begin
      pair_meta <= {dp, dn};
      pair_sync <= pair_meta;
    end
  end

  ////////////////////
  // line state machine

  // any change parks one clock in transition before the new state settles,
  // so a pair that moves one clock apart still lands on the right state
  always_ff @(posedge clk_48mhz) begin
    if (reset) begin
      in_transition <= 1'b0;
      line_state    <= usb_pkg::LS_J;
      bit_phase     <= 2'd0;
    end else begin
      if (in_transition) begin
        in_transition <= 1'b0;
        line_state    <= usb_pkg::line_state_t'(pair_sync);
      end else if (pair_sync != line_state) begin
        in_transition <= 1'b1;
      end
      // phase realigns on every line edge
      bit_phase <= in_transition ? 2'd0 : bit_phase + 2'd1;
    end
  end

  // one strobe per 4 clock bit, near mid bit
  assign sample = !in_transition && (bit_phase == 2'd1);

endmodule

// File: usb_packet_decoder.sv
`timescale 1ns/100ps

module usb_packet_decoder (
  input  logic                  clk_48mhz,
  input  logic                  reset,
  usb_bit_if.consumer           bits,
  output logic                  byte_push,
  output logic [7:0]            byte_data,
  output logic                  rec_push,
  output usb_pkg::usb_pkt_rec_t rec
);

  // pid plus complement, lsb first
  logic [7:0]  pid_sr;
  logic [3:0]  pid_bits;
  logic        pid_done;
  logic        pid_ok;
  logic [4:0]  crc5;
  logic [15:0] crc16;
  logic        crc5_fb;
  logic        crc16_fb;
  logic [10:0] token_sr;
  logic [3:0]  token_bits;
  logic [6:0]  byte_sr;
  logic [2:0]  bit_in_byte;
  logic [9:0]  byte_count;
  logic        body_bit;
  logic        is_token;
  logic        is_data;
  logic        is_handshake;
  logic        pkt_ok;

  assign pid_done = pid_bits[3];
  assign pid_ok   = (pid_sr[3:0] == ~pid_sr[7:4]);
  // every bit after the pid feeds the crcs
  assign body_bit = bits.bit_valid && pid_done;

  assign is_token     = (pid_sr[1:0] == usb_pkg::PT_TOKEN);
  assign is_data      = (pid_sr[1:0] == usb_pkg::PT_DATA);
  assign is_handshake = (pid_sr[1:0] == usb_pkg::PT_HANDSHAKE);

  assign crc5_fb  = bits.bit_data ^ crc5[4];
  assign crc16_fb = bits.bit_data ^ crc16[15];

  // special pids never count as good
  assign pkt_ok = pid_done && pid_ok &&
                  (is_handshake ||
                   (is_token && (crc5 == usb_pkg::CRC5_RESIDUE)) ||
                   (is_data && (crc16 == usb_pkg::CRC16_RESIDUE)));

  ////////////////////
  // bit counters

  always_ff @(posedge clk_48mhz) begin
    if (reset) begin
      pid_bits    <= 4'd0;
      token_bits  <= 4'd0;
      bit_in_byte <= 3'd0;
      byte_count  <= 10'd0;
      byte_push   <= 1'b0;
      rec_push    <= 1'b0;
    end else begin
      byte_push <= 1'b0;
      rec_push  <= bits.done;
      if (bits.start) begin
        pid_bits    <= 4'd0;
        token_bits  <= 4'd0;
        bit_in_byte <= 3'd0;
        byte_count  <= 10'd0;
      end else if (bits.bit_valid && !pid_done) begin
        pid_bits <= pid_bits + 4'd1;
      end else if (body_bit) begin
        if (is_token && (token_bits != 4'd11)) begin
          token_bits <= token_bits + 4'd1;
        end
        if (is_data) begin
          bit_in_byte <= bit_in_byte + 3'd1;
          // eighth bit of a byte, crc bytes included
          if (bit_in_byte == 3'd7) begin
            byte_push  <= 1'b1;
            byte_count <= byte_count + 10'd1;
          end
        end
      end
    end
  end

  ////////////////////
  // shifters and crcs

  always_ff @(posedge clk_48mhz) begin
    if (bits.start) begin
      crc5     <= usb_pkg::CRC5_SEED;
      crc16    <= usb_pkg::CRC16_SEED;
      // non-token packets report a zero payload
      token_sr <= 11'd0;
    end else if (bits.bit_valid && !pid_done) begin
      pid_sr <= {bits.bit_data, pid_sr[7:1]};
    end else if (body_bit) begin
      crc5  <= {crc5[3:0], 1'b0} ^ (crc5_fb ? usb_pkg::CRC5_POLY : 5'd0);
      crc16 <= {crc16[14:0], 1'b0} ^ (crc16_fb ? usb_pkg::CRC16_POLY : 16'd0);
      // addr lands in [6:0], endp in [10:7]
      if (is_token && (token_bits != 4'd11)) begin
        token_sr <= {bits.bit_data, token_sr[10:1]};
      end
      if (is_data) begin
        byte_sr <= {bits.bit_data, byte_sr[6:1]};
        if (bit_in_byte == 3'd7) begin
          byte_data <= {bits.bit_data, byte_sr};
        end
      end
    end

    // record is loaded on the same edge that raises rec_push
    if (bits.done) begin
      rec.pid           <= pid_sr[3:0];
      rec.ok            <= pkt_ok;
      rec.token_payload <= token_sr;
      rec.byte_count    <= byte_count;
    end
  end

endmodule

// File: usb_packet_framer.sv
`timescale 1ns/100ps

module usb_packet_framer (
  input  logic                clk_48mhz,
  input  logic                reset,
  input  usb_pkg::line_state_t line_state,
  input  logic                sample,
  usb_bit_if.producer         bits
);

  // last three sampled states, newest in [1:0]
  logic [5:0] line_hist;
  logic       in_packet;
  // run of decoded ones, a stuffed zero follows six
  logic [2:0] ones_count;
  logic       cur_jk;
  logic       prev_jk;
  logic       nrzi_bit;
  logic       raw_valid;
  logic       stuffed;

  ////////////////////
  // sync and eop

  // tail of sync KJKJKK, the current sample gives the final K
  assign bits.start = sample && !in_packet && (line_state == usb_pkg::LS_K) &&
                      (line_hist == {usb_pkg::LS_K, usb_pkg::LS_J, usb_pkg::LS_K});

  // two se0 samples end the packet
  assign bits.done = sample && in_packet && (line_state == usb_pkg::LS_SE0) &&
                     (line_hist[1:0] == usb_pkg::LS_SE0);

  ////////////////////
  // nrzi and unstuffing

  assign cur_jk  = (line_state == usb_pkg::LS_J) || (line_state == usb_pkg::LS_K);
  assign prev_jk = (line_hist[1:0] == usb_pkg::LS_J) || (line_hist[1:0] == usb_pkg::LS_K);

  // no change on the line means 1
  assign nrzi_bit  = (line_state == line_hist[1:0]);
  assign raw_valid = sample && in_packet && cur_jk && prev_jk;
  assign stuffed   = (ones_count == 3'd6);

  assign bits.bit_valid = raw_valid && !stuffed;
  assign bits.bit_data  = nrzi_bit;

  always_ff @(posedge clk_48mhz) begin
    if (reset) begin
      line_hist  <= {usb_pkg::LS_J, usb_pkg::LS_J, usb_pkg::LS_J};
      in_packet  <= 1'b0;
      ones_count <= 3'd0;
    end else begin
      if (sample) begin
        line_hist <= {line_hist[3:0], line_state};
      end

      if (bits.start) begin
        in_packet <= 1'b1;
      end else if (bits.done) begin
        in_packet <= 1'b0;
      end

      if (bits.start || bits.done) begin
        ones_count <= 3'd0;
      end else if (raw_valid) begin
        // stuffed bit is dropped and breaks the run
        if (stuffed || !nrzi_bit) begin
          ones_count <= 3'd0;
        end else begin
          ones_count <= ones_count + 3'd1;
        end
      end
    end
  end

endmodule

// File: usb_pkg.sv
package usb_pkg;

  ////////////////////
  // line level

  // recovered line state, encoded as the {dp, dn} pair
  typedef enum logic [1:0] {
    LS_SE0 = 2'b00,
    LS_K   = 2'b01,
    LS_J   = 2'b10,
    LS_SE1 = 2'b11
  } line_state_t;

  ////////////////////
  // packet level

  typedef logic [3:0] pid_t;

  // packet type lives in pid bits [1:0]
  localparam logic [1:0] PT_SPECIAL   = 2'b00;
  localparam logic [1:0] PT_TOKEN     = 2'b01;
  localparam logic [1:0] PT_HANDSHAKE = 2'b10;
  localparam logic [1:0] PT_DATA      = 2'b11;

  // crc5 covers token fields, crc16 covers data payloads
  localparam logic [4:0]  CRC5_POLY     = 5'b00101;
  localparam logic [4:0]  CRC5_SEED     = 5'b11111;
  localparam logic [4:0]  CRC5_RESIDUE  = 5'b01100;
  localparam logic [15:0] CRC16_POLY    = 16'h8005;
  localparam logic [15:0] CRC16_SEED    = 16'hffff;
  localparam logic [15:0] CRC16_RESIDUE = 16'b1000000000001101;

  // one record per received packet, 26 bits
  typedef struct packed {
    pid_t        pid;
    logic        ok;
    logic [10:0] token_payload;
    // includes the two crc16 bytes
    logic [9:0]  byte_count;
  } usb_pkt_rec_t;

endpackage

// File: usb_rx_apb_regs.sv
`timescale 1ns/100ps

module usb_rx_apb_regs (
  input  logic                                clk_48mhz,
  input  logic                                reset,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [usb_rx_reg_pkg::APB_ADDR_W-1:0] paddr,
  input  logic [31:0]                         pwdata,
  output logic [31:0]                         prdata,
  output logic                                pready,
  output logic                                pslverr,
  input  usb_pkg::usb_pkt_rec_t               pkt_head,
  input  logic                                pkt_empty,
  input  logic                                pkt_ovf,
  output logic                                pkt_pop,
  output logic                                pkt_ovf_clear,
  input  logic [7:0]                          data_head,
  input  logic                                data_empty,
  input  logic                                data_ovf,
  output logic                                data_pop,
  output logic                                data_ovf_clear
);

  logic        mapped;
  logic        rd_done;
  logic        wr_done;
  logic [31:0] status;

  ////////////////////
  // wait state

  // first access cycle arms pready, second one completes
  always_ff @(posedge clk_48mhz) begin
    if (reset) begin
      pready <= 1'b0;
    end else begin
      pready <= psel && penable && !pready;
    end
  end

  assign mapped = (paddr == usb_rx_reg_pkg::REG_STATUS) ||
                  (paddr == usb_rx_reg_pkg::REG_PKT) ||
                  (paddr == usb_rx_reg_pkg::REG_DATA) ||
                  (paddr == usb_rx_reg_pkg::REG_CLEAR);

  assign pslverr = pready && !mapped;
  assign rd_done = pready && psel && penable && !pwrite;
  assign wr_done = pready && psel && penable && pwrite;

  // pops land on the completing cycle, fifo moves on the next edge
  assign pkt_pop  = rd_done && (paddr == usb_rx_reg_pkg::REG_PKT) && !pkt_empty;
  assign data_pop = rd_done && (paddr == usb_rx_reg_pkg::REG_DATA) && !data_empty;

  // write one to clear
  assign pkt_ovf_clear  = wr_done && (paddr == usb_rx_reg_pkg::REG_CLEAR) &&
                          pwdata[usb_rx_reg_pkg::STAT_PKT_OVF];
  assign data_ovf_clear = wr_done && (paddr == usb_rx_reg_pkg::REG_CLEAR) &&
                          pwdata[usb_rx_reg_pkg::STAT_DATA_OVF];

  ////////////////////
  // read mux

  always_comb begin
    status = 32'd0;
    status[usb_rx_reg_pkg::STAT_PKT_AVAIL]  = !pkt_empty;
    status[usb_rx_reg_pkg::STAT_DATA_AVAIL] = !data_empty;
    status[usb_rx_reg_pkg::STAT_PKT_OVF]    = pkt_ovf;
    status[usb_rx_reg_pkg::STAT_DATA_OVF]   = data_ovf;
  end

  // empty fifos read as zero
  always_comb begin
    prdata = 32'd0;
    case (paddr)
      usb_rx_reg_pkg::REG_STATUS: prdata = status;
      usb_rx_reg_pkg::REG_PKT:    prdata = pkt_empty ? 32'd0 : 32'(pkt_head);
      usb_rx_reg_pkg::REG_DATA:   prdata = data_empty ? 32'd0 : {24'd0, data_head};
      default:                    prdata = 32'd0;
    endcase
  end

endmodule

// File: usb_rx_fifo.sv
`timescale 1ns/100ps

module usb_rx_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clk_48mhz,
  input  logic     reset,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t head,
  output logic     empty,
  output logic     overflow,
  input  logic     ovf_clear
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             do_push;
  logic             do_pop;

  assign full    = (count == CNT_W'(DEPTH));
  assign empty   = (count == '0);
  // a push into a full buffer is lost
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign head    = mem[rd_ptr];

  always_ff @(posedge clk_48mhz) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk_48mhz) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;
      endcase
      // new drop beats a clear in the same cycle
      if (push && full) begin
        overflow <= 1'b1;
      end else if (ovf_clear) begin
        overflow <= 1'b0;
      end
    end
  end

endmodule

// File: usb_rx_reg_pkg.sv
package usb_rx_reg_pkg;

  localparam int APB_ADDR_W = 4;

  // register offsets
  localparam logic [APB_ADDR_W-1:0] REG_STATUS = 4'h0;
  localparam logic [APB_ADDR_W-1:0] REG_PKT    = 4'h4;
  localparam logic [APB_ADDR_W-1:0] REG_DATA   = 4'h8;
  localparam logic [APB_ADDR_W-1:0] REG_CLEAR  = 4'hc;

  // status bit positions, overflow bits are also the w1c positions in REG_CLEAR
  localparam int STAT_PKT_AVAIL  = 0;
  localparam int STAT_DATA_AVAIL = 1;
  localparam int STAT_PKT_OVF    = 2;
  localparam int STAT_DATA_OVF   = 3;

endpackage

// File: usb_rx_top.sv
`timescale 1ns/100ps

module usb_rx_top #(
  parameter int PKT_FIFO_DEPTH  = 4,
  parameter int DATA_FIFO_DEPTH = 64
) (
  input  logic                                clk_48mhz,
  input  logic                                reset,
  input  logic                                dp,
  input  logic                                dn,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [usb_rx_reg_pkg::APB_ADDR_W-1:0] paddr,
  input  logic [31:0]                         pwdata,
  output logic [31:0]                         prdata,
  output logic                                pready,
  output logic                                pslverr
);

  usb_pkg::line_state_t  line_state;
  logic                  sample;
  logic                  byte_push;
  logic [7:0]            byte_data;
  logic                  rec_push;
  usb_pkg::usb_pkt_rec_t rec;
  usb_pkg::usb_pkt_rec_t pkt_head;
  logic                  pkt_empty;
  logic                  pkt_ovf;
  logic                  pkt_pop;
  logic                  pkt_ovf_clear;
  logic [7:0]            data_head;
  logic                  data_empty;
  logic                  data_ovf;
  logic                  data_pop;
  logic                  data_ovf_clear;

  usb_bit_if bit_bus ();

  ////////////////////
  // receive pipeline

  usb_line_recovery line_rec (
    .clk_48mhz (clk_48mhz),
    .reset     (reset),
    .dp        (dp),
    .dn        (dn),
    .line_state(line_state),
    .sample    (sample)
  );

  usb_packet_framer framer (
    .clk_48mhz (clk_48mhz),
    .reset     (reset),
    .line_state(line_state),
    .sample    (sample),
    .bits      (bit_bus)
  );

  usb_packet_decoder decoder (
    .clk_48mhz(clk_48mhz),
    .reset    (reset),
    .bits     (bit_bus),
    .byte_push(byte_push),
    .byte_data(byte_data),
    .rec_push (rec_push),
    .rec      (rec)
  );

  ////////////////////
  // storage and bus

  // one record per packet
  usb_rx_fifo #(
    .payload_t(usb_pkg::usb_pkt_rec_t),
    .DEPTH    (PKT_FIFO_DEPTH)
  ) pkt_fifo (
    .clk_48mhz(clk_48mhz),
    .reset    (reset),
    .push     (rec_push),
    .push_data(rec),
    .pop      (pkt_pop),
    .head     (pkt_head),
    .empty    (pkt_empty),
    .overflow (pkt_ovf),
    .ovf_clear(pkt_ovf_clear)
  );

  // data bytes of all data packets, crc bytes included
  usb_rx_fifo #(
    .payload_t(logic [7:0]),
    .DEPTH    (DATA_FIFO_DEPTH)
  ) data_fifo (
    .clk_48mhz(clk_48mhz),
    .reset    (reset),
    .push     (byte_push),
    .push_data(byte_data),
    .pop      (data_pop),
    .head     (data_head),
    .empty    (data_empty),
    .overflow (data_ovf),
    .ovf_clear(data_ovf_clear)
  );

  usb_rx_apb_regs regs (
    .clk_48mhz     (clk_48mhz),
    .reset         (reset),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .pkt_head      (pkt_head),
    .pkt_empty     (pkt_empty),
    .pkt_ovf       (pkt_ovf),
    .pkt_pop       (pkt_pop),
    .pkt_ovf_clear (pkt_ovf_clear),
    .data_head     (data_head),
    .data_empty    (data_empty),
    .data_ovf      (data_ovf),
    .data_pop      (data_pop),
    .data_ovf_clear(data_ovf_clear)
  );

endmodule
